/* project.f */
+incdir+source
source/psyn_pkg.sv
source/note_if.sv
source/midi_note_register.sv
source/half_period_timer.sv
source/edge_sequencer.sv
source/pulse_synth_top.sv
dv/pulse_synth_checks.sv
dv/pulse_synth_tb.sv

/* Bender.yml */
package:
  name: pulse_synth

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/psyn_pkg.sv
      - source/note_if.sv
      - source/midi_note_register.sv
      - source/half_period_timer.sv
      - source/edge_sequencer.sv
      - source/pulse_synth_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/pulse_synth_checks.sv
      - dv/pulse_synth_tb.sv

/* dv/pulse_synth_tb.sv */
// Pulse synth testbench with clock, reset, watchdog and random note stimulus

`default_nettype none

module pulse_synth_tb;

    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYCLES  = 16;
    localparam int SLOT_CYCLES   = 8;
    localparam int PLANNED_SLOTS = 6000;
    localparam int TIMEOUT       = PLANNED_SLOTS * SLOT_CYCLES * CLK_PERIOD * 2;

    logic                clk;
    logic                reset;
    logic                midi_rdy;
    psyn_pkg::midi_cmd_t midi_cmd;
    psyn_pkg::note_t     midi_data0;
    psyn_pkg::velocity_t midi_data1;
    logic                sample_trig;
    logic                sample_valid;
    psyn_pkg::sample_t   sample;
    logic                check_error;

    logic [31:0]         rnd_state;

    pulse_synth_top dut0 (
        .i_clk          (clk),
        .i_reset        (reset),
        .i_midi_rdy     (midi_rdy),
        .i_midi_cmd     (midi_cmd),
        .i_midi_data0   (midi_data0),
        .i_midi_data1   (midi_data1),
        .i_sample_trig  (sample_trig),
        .o_sample_valid (sample_valid),
        .o_sample       (sample)
    );

    pulse_synth_checks checks0 (
        .i_clk          (clk),
        .i_reset        (reset),
        .i_midi_rdy     (midi_rdy),
        .i_midi_cmd     (midi_cmd),
        .i_midi_data0   (midi_data0),
        .i_midi_data1   (midi_data1),
        .i_sample_trig  (sample_trig),
        .i_sample_valid (sample_valid),
        .i_sample       (sample),
        .o_error        (check_error)
    );

    // --------------------
    // Clock and watchdog
    // --------------------
    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    initial begin
        #(TIMEOUT);
        $display("Timeout: the test sequence did not finish in time");
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped by watchdog");
    end

    always @(posedge check_error) begin
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at first failed check");
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int next_random();
        rnd_state = xorshift(rnd_state);
        return int'(rnd_state & 32'h7fff_ffff);
    endfunction

    // One slot is a trigger followed by seven quiet cycles
    task automatic run_slots(input int n);
        repeat (n) begin
            @(posedge clk);
            #5;
            sample_trig = 1'b1;
            @(posedge clk);
            #5;
            sample_trig = 1'b0;
            repeat (SLOT_CYCLES - 2) @(posedge clk);
        end
    endtask

    // MIDI strobe sits mid-slot away from any trigger
    task automatic send_midi(input logic [3:0] cmd, input int note, input int vel);
        repeat (4) @(posedge clk);
        #5;
        midi_rdy   = 1'b1;
        midi_cmd   = cmd;
        midi_data0 = 7'(note);
        midi_data1 = 7'(vel);
        @(posedge clk);
        #5;
        midi_rdy = 1'b0;
        repeat (SLOT_CYCLES - 5) @(posedge clk);
    endtask

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        int vel;

        rnd_state   = 32'hdb47;
        reset       = 1'b1;
        midi_rdy    = 1'b0;
        midi_cmd    = '0;
        midi_data0  = '0;
        midi_data1  = '0;
        sample_trig = 1'b0;

        repeat (RESET_CYCLES) @(posedge clk);
        #5;
        reset = 1'b0;

        // Idle output before any note
        run_slots(10);

        // Octave 9 note with a long half period
        vel = 1 + next_random() % 127;
        send_midi(4'd9, 112, vel);
        run_slots(3000 + next_random() % 400);
        send_midi(4'd8, 112, 0);
        run_slots(200);

        // Octave 10 note with a shorter half period
        vel = 1 + next_random() % 127;
        send_midi(4'd9, 125, vel);
        run_slots(1500 + next_random() % 300);
        send_midi(4'd8, 125, 0);
        run_slots(100);

        if (check_error) begin
            $display("ERRORS FOUND");
            $fatal(1, "checks failed");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* dv/pulse_synth_checks.sv */
// Pulse synth checker with a waveform model and assertions on the top-level ports

`default_nettype none

`include "psyn_settings.svh"

module pulse_synth_checks (
    input  logic                i_clk,
    input  logic                i_reset,
    input  logic                i_midi_rdy,
    input  psyn_pkg::midi_cmd_t i_midi_cmd,
    input  psyn_pkg::note_t     i_midi_data0,
    input  psyn_pkg::velocity_t i_midi_data1,
    input  logic                i_sample_trig,
    input  logic                i_sample_valid,
    input  psyn_pkg::sample_t   i_sample,
    output logic                o_error
);

    int                note;
    int                vel;
    bit                active;
    bit                pend_on;
    bit                pend_off;
    bit                seen_on;
    int                cnt;
    int                phase;
    int                idx;
    bit                latch;
    logic signed [17:0] exp_sample;

    // Lowest octave base counts, halved per octave
    function automatic int half_period_cycles(input int n);
        int base [12] = '{6115460, 5772226, 5448256, 5142469, 4853844, 4581419,
                          4324284, 4081580, 3852499, 3636274, 3432186, 3239552};
        return base[n % `PSYN_SEMITONES] >> (n / `PSYN_SEMITONES);
    endfunction

    // --------------------
    // Reference model
    // --------------------
    // Phase 0 idle then rise, hold and fall for plus (1 to 3) and minus (4 to 6)
    always @(posedge i_clk or posedge i_reset) begin
        bit done;
        bit old_latch;
        int mag;
        if (i_reset) begin
            note       = 0;
            vel        = 0;
            cnt        = 0;
            phase      = 0;
            idx        = 0;
            active     = 0;
            pend_on    = 0;
            pend_off   = 0;
            seen_on    = 0;
            latch      = 0;
            exp_sample = '0;
            o_error    = 1'b0;
        end else begin
            done      = (cnt == half_period_cycles(note));
            old_latch = latch;
            cnt       = (pend_on || pend_off || done) ? 0 : cnt + 1;
            if (pend_on) begin
                phase = 1;
                idx   = 0;
                latch = 0;
            end else if (!active) begin
                phase = 0;
                idx   = 0;
                latch = 0;
            end else begin
                if ((phase == 2 || phase == 5) && done) latch = 1;
                if (i_sample_trig) begin
                    if (phase == 1 || phase == 4) begin
                        idx = idx + 1;
                        if (idx == `PSYN_RAMP_STEPS) phase = phase + 1;
                    end else if ((phase == 2 || phase == 5) && old_latch) begin
                        phase = phase + 1;
                        latch = 0;
                    end else if (phase == 3 || phase == 6) begin
                        idx = idx - 1;
                        if (idx == 0) phase = (phase == 3) ? 4 : 1;
                    end
                end
            end
            if (i_sample_trig) begin
                mag        = (vel * idx) << `PSYN_LEVEL_SHIFT;
                exp_sample = (phase == 0) ? 18'sd0 : (phase >= 4) ? 18'(-mag) : 18'(mag);
            end
            // Note register sees the strobe one cycle ahead of the sequencer
            pend_on  = i_midi_rdy && (i_midi_cmd == `PSYN_CMD_NOTE_ON);
            pend_off = i_midi_rdy && (i_midi_cmd == `PSYN_CMD_NOTE_OFF);
            if (pend_on) begin
                note    = int'(i_midi_data0);
                vel     = int'(i_midi_data1);
                active  = 1;
                seen_on = 1;
            end else if (pend_off) begin
                active = 0;
            end
        end
    end

    a_valid_timing: assert property (
        @(posedge i_clk) disable iff (i_reset)
        i_sample_valid == $past(i_sample_trig)
    ) else begin
        $display("Fail at %0t: sample valid does not follow the trigger", $time);
        o_error = 1'b1;
    end

    a_quiet_before_note: assert property (
        @(posedge i_clk) disable iff (i_reset)
        (i_sample_valid && !seen_on) |-> (i_sample == '0)
    ) else begin
        $display("Fail at %0t: sample %0d before any note-on", $time, i_sample);
        o_error = 1'b1;
    end

    a_sample_value: assert property (
        @(posedge i_clk) disable iff (i_reset)
        i_sample_valid |-> (i_sample == exp_sample)
    ) else begin
        $display("Fail at %0t: sample %0d, expected %0d", $time, i_sample, exp_sample);
        o_error = 1'b1;
    end

endmodule

`default_nettype wire

/* source/pulse_synth_top.sv */
// Pulse synth top that joins the note register, half-period timer and sequencer

`default_nettype none

`include "psyn_settings.svh"

module pulse_synth_top (
    input  logic                i_clk,
    input  logic                i_reset,
    input  logic                i_midi_rdy,
    input  psyn_pkg::midi_cmd_t i_midi_cmd,
    input  psyn_pkg::note_t     i_midi_data0,
    input  psyn_pkg::velocity_t i_midi_data1,
    input  logic                i_sample_trig,
    output logic                o_sample_valid,
    output psyn_pkg::sample_t   o_sample
);

    note_if note_bus ();

    logic half_period_done;

    // --------------------
    // Blocks
    // --------------------
    midi_note_register u_note_reg (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_midi_rdy   (i_midi_rdy),
        .i_midi_cmd   (i_midi_cmd),
        .i_midi_data0 (i_midi_data0),
        .i_midi_data1 (i_midi_data1),
        .o_note       (note_bus.owner)
    );

    half_period_timer u_timer (
        .i_clk              (i_clk),
        .i_reset            (i_reset),
        .i_note             (note_bus.timer),
        .o_half_period_done (half_period_done)
    );

    edge_sequencer u_seq (
        .i_clk              (i_clk),
        .i_reset            (i_reset),
        .i_note             (note_bus.player),
        .i_half_period_done (half_period_done),
        .i_sample_trig      (i_sample_trig),
        .o_sample_valid     (o_sample_valid),
        .o_sample           (o_sample)
    );

endmodule

`default_nettype wire

/* source/edge_sequencer.sv */
// Edge sequencer FSM that steps the ramped bipolar pulse and forms each sample

`default_nettype none

`include "psyn_settings.svh"

module edge_sequencer (
    input  logic              i_clk,
    input  logic              i_reset,
    note_if.player            i_note,
    input  logic              i_half_period_done,
    input  logic              i_sample_trig,
    output logic              o_sample_valid,
    output psyn_pkg::sample_t o_sample
);

    psyn_pkg::seq_state_t  state;
    psyn_pkg::seq_state_t  state_nxt;
    psyn_pkg::ramp_index_t idx;
    psyn_pkg::ramp_index_t idx_nxt;
    logic                  held;
    logic                  held_nxt;
    logic                  holding;
    logic [13:0]           prod;
    logic [16:0]           mag;
    psyn_pkg::sample_t     sample_nxt;

    assign holding = (state == psyn_pkg::SEQ_HOLD_POS) ||
                     (state == psyn_pkg::SEQ_HOLD_NEG);

    // --------------------
    // Next state
    // --------------------
    always_comb begin
        state_nxt = state;
        idx_nxt   = idx;
        held_nxt  = held;

        if (i_note.note_on) begin
            state_nxt = psyn_pkg::SEQ_RISE_POS;
            idx_nxt   = '0;
            held_nxt  = 1'b0;
        end else if (!i_note.active) begin
            state_nxt = psyn_pkg::SEQ_IDLE;
            idx_nxt   = '0;
            held_nxt  = 1'b0;
        end else begin
            // Half period ends while holding
            if (holding && i_half_period_done) begin
                held_nxt = 1'b1;
            end

            if (i_sample_trig) begin
                case (state)
                    psyn_pkg::SEQ_RISE_POS: begin
                        idx_nxt = idx + 1'b1;
                        if (idx_nxt == `PSYN_RAMP_STEPS) begin
                            state_nxt = psyn_pkg::SEQ_HOLD_POS;
                        end
                    end
                    psyn_pkg::SEQ_HOLD_POS: begin
                        if (held) begin
                            state_nxt = psyn_pkg::SEQ_FALL_POS;
                            held_nxt  = 1'b0;
                        end
                    end
                    psyn_pkg::SEQ_FALL_POS: begin
                        idx_nxt = idx - 1'b1;
                        if (idx_nxt == '0) begin
                            state_nxt = psyn_pkg::SEQ_RISE_NEG;
                        end
                    end
                    psyn_pkg::SEQ_RISE_NEG: begin
                        idx_nxt = idx + 1'b1;
                        if (idx_nxt == `PSYN_RAMP_STEPS) begin
                            state_nxt = psyn_pkg::SEQ_HOLD_NEG;
                        end
                    end
                    psyn_pkg::SEQ_HOLD_NEG: begin
                        if (held) begin
                            state_nxt = psyn_pkg::SEQ_FALL_NEG;
                            held_nxt  = 1'b0;
                        end
                    end
                    psyn_pkg::SEQ_FALL_NEG: begin
                        idx_nxt = idx - 1'b1;
                        if (idx_nxt == '0) begin
                            state_nxt = psyn_pkg::SEQ_RISE_POS;
                        end
                    end
                    default: begin
                        state_nxt = psyn_pkg::SEQ_IDLE;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            state <= psyn_pkg::SEQ_IDLE;
            idx   <= '0;
            held  <= 1'b0;
        end else begin
            state <= state_nxt;
            idx   <= idx_nxt;
            held  <= held_nxt;
        end
    end

    // --------------------
    // Sample forming
    // --------------------
    assign prod = i_note.velocity * idx_nxt;
    assign mag  = 17'(prod) << `PSYN_LEVEL_SHIFT;

    always_comb begin
        case (state_nxt)
            psyn_pkg::SEQ_IDLE: begin
                sample_nxt = '0;
            end
            psyn_pkg::SEQ_RISE_NEG, psyn_pkg::SEQ_HOLD_NEG, psyn_pkg::SEQ_FALL_NEG: begin
                sample_nxt = -$signed({1'b0, mag});
            end
            default: begin
                sample_nxt = $signed({1'b0, mag});
            end
        endcase
    end

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            o_sample_valid <= 1'b0;
        end else begin
            o_sample_valid <= i_sample_trig;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_sample_trig) begin
            o_sample <= sample_nxt;
        end
    end

    a_index_range: assert property (
        @(posedge i_clk) disable iff (i_reset)
        idx <= `PSYN_RAMP_STEPS
    );

    a_valid_after_trig: assert property (
        @(posedge i_clk) disable iff (i_reset)
        o_sample_valid |-> $past(i_sample_trig)
    );

endmodule

`default_nettype wire

/* source/half_period_timer.sv */
// Half-period timer that maps the held note to a divider and counts it out

`default_nettype none

`include "psyn_settings.svh"

module half_period_timer (
    input  logic   i_clk,
    input  logic   i_reset,
    note_if.timer  i_note,
    output logic   o_half_period_done
);

    logic [3:0]         semitone;
    logic [3:0]         octave;
    psyn_pkg::divider_t base;
    psyn_pkg::divider_t divider;
    psyn_pkg::divider_t cnt;
    logic               cnt_end;

    assign semitone = 4'(i_note.note % `PSYN_SEMITONES);
    assign octave   = 4'(i_note.note / `PSYN_SEMITONES);

    // --------------------
    // Lowest octave dividers
    // --------------------
    always_comb begin
        case (semitone)
            4'd0:    base = 24'h5d5084;
            4'd1:    base = 24'h5813c2;
            4'd2:    base = 24'h532240;
            4'd3:    base = 24'h4e77c5;
            4'd4:    base = 24'h4a1054;
            4'd5:    base = 24'h45e82b;
            4'd6:    base = 24'h41fbbc;
            4'd7:    base = 24'h3e47ac;
            4'd8:    base = 24'h3ac8d3;
            4'd9:    base = 24'h377c32;
            4'd10:   base = 24'h345efa;
            4'd11:   base = 24'h316e80;
            default: base = 24'hffffff;
        endcase
    end

    // One octave up halves the period
    assign divider = base >> octave;

    // --------------------
    // Cycle counter
    // --------------------
    assign cnt_end = (cnt == divider);

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            cnt <= '0;
        end else if (i_note.note_on || i_note.note_off || cnt_end) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    assign o_half_period_done = cnt_end;

    // A new note may shorten the divider so the restart must follow at once
    a_cnt_in_range: assert property (
        @(posedge i_clk) disable iff (i_reset)
        !i_note.note_on |-> (cnt <= divider)
    );

endmodule

`default_nettype wire

/* source/midi_note_register.sv */
// MIDI note register that decodes note-on/off and holds note, velocity and gate

`default_nettype none

`include "psyn_settings.svh"

module midi_note_register (
    input  logic                i_clk,
    input  logic                i_reset,
    input  logic                i_midi_rdy,
    input  psyn_pkg::midi_cmd_t i_midi_cmd,
    input  psyn_pkg::note_t     i_midi_data0,
    input  psyn_pkg::velocity_t i_midi_data1,
    note_if.owner               o_note
);

    logic note_on_evt;
    logic note_off_evt;

    assign note_on_evt  = i_midi_rdy && (i_midi_cmd == `PSYN_CMD_NOTE_ON);
    assign note_off_evt = i_midi_rdy && (i_midi_cmd == `PSYN_CMD_NOTE_OFF);

    // --------------------
    // Held note
    // --------------------
    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            o_note.note     <= '0;
            o_note.velocity <= '0;
        end else if (note_on_evt) begin
            o_note.note     <= i_midi_data0;
            o_note.velocity <= i_midi_data1;
        end
    end

    // Gate alone drops on note-off and the held note stays
    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            o_note.active <= 1'b0;
        end else if (note_on_evt) begin
            o_note.active <= 1'b1;
        end else if (note_off_evt) begin
            o_note.active <= 1'b0;
        end
    end

    // Event pulses line up with the register update
    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            o_note.note_on  <= 1'b0;
            o_note.note_off <= 1'b0;
        end else begin
            o_note.note_on  <= note_on_evt;
            o_note.note_off <= note_off_evt;
        end
    end

    a_single_event: assert property (
        @(posedge i_clk) disable iff (i_reset)
        !(o_note.note_on && o_note.note_off)
    );

endmodule

`default_nettype wire

/* source/note_if.sv */
// Note state bus from the MIDI register block to the timer and the sequencer

`default_nettype none

interface note_if;

    // Held values, kept across a note-off
    psyn_pkg::note_t     note;
    psyn_pkg::velocity_t velocity;

    // High from note-on until note-off
    logic                active;

    // One-cycle event pulses
    logic                note_on;
    logic                note_off;

    modport owner (
        output note, velocity, active, note_on, note_off
    );

    modport timer (
        input note, note_on, note_off
    );

    modport player (
        input velocity, active, note_on
    );

endinterface

`default_nettype wire

/* source/psyn_pkg.sv */
// Pulse synth package with the shared vector types and sequencer states

`default_nettype none

`include "psyn_settings.svh"

package psyn_pkg;

    // MIDI fields
    typedef logic [3:0] midi_cmd_t;
    typedef logic [6:0] note_t;
    typedef logic [6:0] velocity_t;

    // Half-period length in clock cycles
    typedef logic [23:0] divider_t;

    // 0 up to and including a full ramp
    typedef logic [$clog2(`PSYN_RAMP_STEPS + 1)-1:0] ramp_index_t;

    typedef logic signed [17:0] sample_t;

    // --------------------
    // Waveform phases
    // --------------------
    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_RISE_POS,
        SEQ_HOLD_POS,
        SEQ_FALL_POS,
        SEQ_RISE_NEG,
        SEQ_HOLD_NEG,
        SEQ_FALL_NEG
    } seq_state_t;

endpackage

`default_nettype wire

/* source/psyn_settings.svh */
// Pulse synth constants for MIDI command decode, edge ramps and output level

`ifndef PSYN_SETTINGS_SVH
`define PSYN_SETTINGS_SVH

// --------------------
// MIDI command nibbles
// --------------------
`define PSYN_CMD_NOTE_ON  4'd9
`define PSYN_CMD_NOTE_OFF 4'd8

// --------------------
// Waveform shape
// --------------------

// Sample triggers per edge ramp
`define PSYN_RAMP_STEPS 64

// Notes per octave, used for the divider octave shift
`define PSYN_SEMITONES 12

// Velocity times ramp index is scaled up by this much
`define PSYN_LEVEL_SHIFT 3

`endif
